//--- list.f
source/icache_pkg.sv
source/icache_controller.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_top.sv
verif/icache_sva.sv
verif/icache_checker.sv
verif/icache_tb.sv

//--- source/icache_controller.sv
`timescale 1ns/10ps

module icache_controller (
  input  logic clk_i,
  input  logic rst_ni,

  // Fetch request side
  input  logic req_i,
  input  logic kill_i,
  output logic ack_o,

  // Lookup result from the tag array
  input  logic hit_i,

  // Memory handshake
  input  logic mem_ack_i,
  output logic mem_req_o,

  // Line, tag and valid write strobe
  output logic refill_o
);

  icache_pkg::icache_state_e state_q;
  icache_pkg::icache_state_e state_d;

  // Request that may be looked up this cycle
  logic lookup;
  // Qualified lookup results
  logic hit_req;
  logic miss_req;
  // Registered fetch acknowledge
  logic ack_q;

  // No lookup while the previous answer is on the bus
  // so a held request is only acknowledged once
  assign lookup = req_i & ~ack_q & ~kill_i;

  assign hit_req  = lookup & hit_i;
  assign miss_req = lookup & ~hit_i;

  // State register
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= icache_pkg::ICACHE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state and memory side strobes
  always_comb begin
    state_d   = state_q;
    mem_req_o = 1'b0;
    refill_o  = 1'b0;

    unique case (state_q)
      icache_pkg::ICACHE_IDLE: begin
        // Miss goes straight out to memory in the same cycle
        if (miss_req) begin
          mem_req_o = 1'b1;
          state_d   = icache_pkg::ICACHE_READ_MEMORY;
        end
      end

      icache_pkg::ICACHE_READ_MEMORY: begin
        if (mem_ack_i) begin
          // Line is on mem_data_i now, write it on this edge
          refill_o = 1'b1;
          state_d  = icache_pkg::ICACHE_IDLE;
        end else begin
          // Hold the request until memory answers
          mem_req_o = 1'b1;
        end
      end

      default: begin
        state_d = icache_pkg::ICACHE_IDLE;
      end
    endcase

    // Redirect from fetch wins over everything
    // Memory drops the read once mem_req_o falls
    if (kill_i) begin
      state_d   = icache_pkg::ICACHE_IDLE;
      mem_req_o = 1'b0;
      refill_o  = 1'b0;
    end
  end

  // One cycle hit latency
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit_req;
    end
  end

  assign ack_o = ack_q;

endmodule

//--- source/icache_data_array.sv
`timescale 1ns/10ps

module icache_data_array (
  input  logic                          clk_i,

  // Set and word select
  input  icache_pkg::icache_addr_u      addr_i,

  // Read port
  input  logic                          read_way_i,
  output logic [icache_pkg::DATA_W-1:0] word_o,

  // Refill port, whole line at once
  input  logic                          write_i,
  input  logic                          write_way_i,
  input  logic [icache_pkg::LINE_W-1:0] line_i
);

  // Line storage, no reset needed
  logic [icache_pkg::LINE_W-1:0] data_q [icache_pkg::WAYS][icache_pkg::SETS];

  logic [icache_pkg::IDX_W-1:0] idx;
  logic [icache_pkg::OFS_W-1:0] ofs;

  // Selected line split into words, word 0 in the low bits
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::DATA_W-1:0] rd_line;

  assign idx = addr_i.fields.index;
  assign ofs = addr_i.fields.word_ofs;

  // Refill write
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      data_q[write_way_i][idx] <= line_i;
    end
  end

  // Combinational read of the hitting way
  assign rd_line = data_q[read_way_i][idx];
  assign word_o  = rd_line[ofs];

endmodule

//--- source/icache_pkg.sv
package icache_pkg;

  // Fetch and memory word sizes
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Line geometry
  localparam int LINE_WORDS = 4;
  localparam int LINE_W = LINE_WORDS * DATA_W;

  // Two ways of sixteen sets
  localparam int SETS = 16;
  localparam int WAYS = 2;

  // Address split
  localparam int IDX_W = 4;
  localparam int OFS_W = 2;
  // Two low bits select the byte inside a word
  localparam int TAG_W = ADDR_W - IDX_W - OFS_W - 2;

  // Fetch address, seen either as a plain word or as cache fields
  typedef union packed {
    // Whole address as driven by the fetch stage
    logic [ADDR_W-1:0] raw;
    // Lookup view, tag on top
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] index;
      logic [OFS_W-1:0] word_ofs;
      logic [1:0]       byte_ofs;
    } fields;
  } icache_addr_u;

  // Controller states
  typedef enum logic [1:0] {
    // Waiting for a miss
    ICACHE_IDLE        = 2'b00,
    // Line read outstanding on the memory side
    ICACHE_READ_MEMORY = 2'b01
  } icache_state_e;

endpackage

//--- source/icache_tag_array.sv
`timescale 1ns/10ps

module icache_tag_array (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Invalidate every line
  input  logic                     flush_i,
  // Write the tag of addr_i into the victim way
  input  logic                     refill_i,

  // Current fetch address
  input  icache_pkg::icache_addr_u addr_i,

  output logic                     hit_o,
  output logic                     hit_way_o,
  output logic                     victim_way_o
);

  // Tag storage, one entry per way and set
  logic [icache_pkg::TAG_W-1:0] tag_q [icache_pkg::WAYS][icache_pkg::SETS];

  // Valid bit per way and set
  logic [icache_pkg::WAYS-1:0][icache_pkg::SETS-1:0] valid_q;

  // One LRU bit per set, names the way to replace next
  logic [icache_pkg::SETS-1:0] lru_q;

  logic [icache_pkg::IDX_W-1:0] idx;
  logic [icache_pkg::TAG_W-1:0] tag;
  logic [icache_pkg::WAYS-1:0]  way_hit;

  assign idx = addr_i.fields.index;
  assign tag = addr_i.fields.tag;

  // Compare both ways of the indexed set in parallel
  always_comb begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
    end
  end

  assign hit_o     = |way_hit;
  // Way 1 hitting means way 1, otherwise way 0 or no hit
  assign hit_way_o = way_hit[1];

  assign victim_way_o = lru_q[idx];

  // Tags need no reset, valid bits guard them
  always_ff @(posedge clk_i) begin
    if (refill_i) begin
      tag_q[victim_way_o][idx] <= tag;
    end
  end

  // Valid bits
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      // Like fence.i, drop the whole cache
      valid_q <= '0;
    end else if (refill_i) begin
      valid_q[victim_way_o][idx] <= 1'b1;
    end
  end

  // LRU bits
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lru_q <= '0;
    end else if (refill_i) begin
      // Freshly filled way becomes most recent
      lru_q[idx] <= ~victim_way_o;
    end else if (hit_o) begin
      // Point away from the way just used
      lru_q[idx] <= ~hit_way_o;
    end
  end

endmodule

//--- source/icache_top.sv
`timescale 1ns/10ps

module icache_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Fetch side
  input  logic                          req_i,
  input  logic                          kill_i,
  input  logic [icache_pkg::ADDR_W-1:0] addr_i,
  output logic                          ack_o,
  output logic [icache_pkg::DATA_W-1:0] instr_o,

  // Cache maintenance
  input  logic                          flush_i,

  // Memory side
  output logic                          mem_req_o,
  output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
  input  logic                          mem_ack_i,
  input  logic [icache_pkg::LINE_W-1:0] mem_data_i
);

  icache_pkg::icache_addr_u addr_u;
  icache_pkg::icache_addr_u line_addr;

  logic                          hit;
  logic                          hit_way;
  logic                          victim_way;
  logic                          refill;
  logic [icache_pkg::DATA_W-1:0] rd_word;
  logic [icache_pkg::DATA_W-1:0] instr_q;

  // Fetch address in field form
  assign addr_u.raw = addr_i;

  // Memory reads whole lines, so clear both offsets
  always_comb begin
    line_addr                 = addr_u;
    line_addr.fields.word_ofs = '0;
    line_addr.fields.byte_ofs = '0;
  end

  assign mem_addr_o = line_addr.raw;

  icache_controller u_controller (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .kill_i    (kill_i),
    .hit_i     (hit),
    .mem_ack_i (mem_ack_i),
    .mem_req_o (mem_req_o),
    .refill_o  (refill),
    .ack_o     (ack_o)
  );

  icache_tag_array u_tag_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .refill_i     (refill),
    .addr_i       (addr_u),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  // Read from the hitting way, refill into the victim
  icache_data_array u_data_array (
    .clk_i       (clk_i),
    .addr_i      (addr_u),
    .read_way_i  (hit_way),
    .word_o      (rd_word),
    .write_i     (refill),
    .write_way_i (victim_way),
    .line_i      (mem_data_i)
  );

  // Instruction word lines up with the registered ack
  always_ff @(posedge clk_i) begin
    if (hit) begin
      instr_q <= rd_word;
    end
  end

  assign instr_o = instr_q;

endmodule

//--- verif/icache_checker.sv
`timescale 1ns/10ps

module icache_checker (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Fetch side as driven and answered
  input  logic                          req_i,
  input  logic                          kill_i,
  input  logic                          flush_i,
  input  logic [icache_pkg::ADDR_W-1:0] addr_i,
  input  logic                          ack_i,
  input  logic [icache_pkg::DATA_W-1:0] instr_i,

  // Memory side
  input  logic                          mem_req_i,
  input  logic [icache_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic                          mem_ack_i,

  output int                            error_count_o,
  output int                            hit_count_o,
  output int                            miss_count_o
);

  // Each memory word is its byte address scrambled with this key
  localparam logic [31:0] CONTENT_KEY = 32'h5a5a_0000;

  // Reference tag store
  logic [icache_pkg::TAG_W-1:0] ref_tag [icache_pkg::WAYS][icache_pkg::SETS];
  logic ref_valid [icache_pkg::WAYS][icache_pkg::SETS];
  // Way to replace next in each set
  logic ref_lru [icache_pkg::SETS];

  // Line read still open on the memory side
  logic ref_busy;
  // Acknowledge owed in the current cycle and the address it answers
  logic ack_due;
  logic [icache_pkg::ADDR_W-1:0] ack_addr;

  icache_pkg::icache_addr_u cur;

  int errors = 0;
  int hits = 0;
  int misses = 0;

  assign cur.raw       = addr_i;
  assign error_count_o = errors;
  assign hit_count_o   = hits;
  assign miss_count_o  = misses;

  function automatic logic [31:0] expected_word(logic [31:0] byte_addr);
    return {byte_addr[31:2], 2'b00} ^ CONTENT_KEY;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("Mismatch %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
  endtask

  // Sampled at the rising edge, so every value is the one the DUT acts on
  always @(posedge clk_i) begin : model_step
    logic [icache_pkg::IDX_W-1:0] idx;
    logic [icache_pkg::WAYS-1:0]  way_hit;
    logic                         hit;
    logic                         lookup;
    logic                         mem_req_exp;
    logic                         victim;

    idx = cur.fields.index;
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      way_hit[w] = ref_valid[w][idx] && (ref_tag[w][idx] == cur.fields.tag);
    end
    hit = |way_hit;

    if (!rst_ni) begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        for (int s = 0; s < icache_pkg::SETS; s++) begin
          ref_valid[w][s] = 1'b0;
        end
      end
      for (int s = 0; s < icache_pkg::SETS; s++) begin
        ref_lru[s] = 1'b0;
      end
      ref_busy = 1'b0;
      ack_due  = 1'b0;
    end else begin
      // Hits answer one cycle after the lookup, with the addressed word
      if (ack_i !== ack_due) begin
        report_mismatch("ack_o", ack_due, ack_i);
      end else if (ack_due && (instr_i !== expected_word(ack_addr))) begin
        report_mismatch("instr_o", expected_word(ack_addr), instr_i);
      end

      // No lookup while an answer is on the bus
      lookup = req_i && !ack_due && !kill_i;

      // Held while a read is open, raised at once on a fresh miss
      if (ref_busy) begin
        mem_req_exp = !mem_ack_i && !kill_i;
      end else begin
        mem_req_exp = lookup && !hit;
      end
      if (mem_req_i !== mem_req_exp) begin
        report_mismatch("mem_req_o", mem_req_exp, mem_req_i);
      end else if (mem_req_exp &&
                   (mem_addr_i !== {cur.fields.tag, cur.fields.index, 4'h0})) begin
        report_mismatch("mem_addr_o", {cur.fields.tag, cur.fields.index, 4'h0}, mem_addr_i);
      end

      if (lookup && hit) begin
        hits++;
      end
      if (lookup && !hit && !ref_busy) begin
        misses++;
      end

      // Refill goes to the LRU way, a hit just moves LRU away from its way
      if (ref_busy && mem_ack_i && !kill_i) begin
        victim                  = ref_lru[idx];
        ref_tag[victim][idx]    = cur.fields.tag;
        ref_valid[victim][idx]  = 1'b1;
        ref_lru[idx]            = ~victim;
      end else if (hit) begin
        ref_lru[idx] = ~way_hit[1];
      end

      // fence.i style flush
      if (flush_i) begin
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
          for (int s = 0; s < icache_pkg::SETS; s++) begin
            ref_valid[w][s] = 1'b0;
          end
        end
      end

      if (kill_i) begin
        ref_busy = 1'b0;
      end else if (ref_busy) begin
        ref_busy = !mem_ack_i;
      end else begin
        ref_busy = lookup && !hit;
      end
      ack_due  = lookup && hit;
      ack_addr = addr_i;
    end
  end

endmodule

//--- verif/icache_sva.sv
`timescale 1ns/10ps

module icache_sva (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          kill_i,
  input  logic                          ack_i,
  input  logic                          mem_req_i,
  input  logic [icache_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic                          mem_ack_i,
  input  icache_pkg::icache_state_e     state_i
);

  // Count of failed properties
  int error_count = 0;

  // Open line read keeps its request and address until memory answers or fetch kills it
  mem_req_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_ack_i && !kill_i |=>
      mem_ack_i || kill_i || (mem_req_i && $stable(mem_addr_i))
  ) else begin
    error_count++;
    $error("mem_req_o fell or mem_addr_o moved before mem_ack_i or kill_i");
  end

  // A held request gets one acknowledge only
  ack_single : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> !ack_i
  ) else begin
    error_count++;
    $error("ack_o high on two cycles in a row");
  end

  // Quiet outputs and idle controller once reset has been applied
  reset_quiet : assert property (
    @(posedge clk_i)
    !rst_ni |=> !ack_i && !mem_req_i && (state_i == icache_pkg::ICACHE_IDLE)
  ) else begin
    error_count++;
    $error("ack_o, mem_req_o or controller state not cleared by reset");
  end

endmodule

bind icache_top icache_sva u_sva (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .kill_i     (kill_i),
  .ack_i      (ack_o),
  .mem_req_i  (mem_req_o),
  .mem_addr_i (mem_addr_o),
  .mem_ack_i  (mem_ack_i),
  .state_i    (u_controller.state_q)
);

//--- verif/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

  // Run length and cycle budget
  localparam int NUM_REQS   = 400;
  localparam int MAX_CYCLES = NUM_REQS * 12;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] SEED      = 32'ha11;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Each memory word is its byte address scrambled with this key
  localparam logic [31:0] CONTENT_KEY = 32'h5a5a_0000;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req_i;
  logic                          kill_i;
  logic                          flush_i;
  logic [icache_pkg::ADDR_W-1:0] addr_i;
  logic                          ack_o;
  logic [icache_pkg::DATA_W-1:0] instr_o;
  logic                          mem_req_o;
  logic [icache_pkg::ADDR_W-1:0] mem_addr_o;
  logic                          mem_ack_i;
  logic [icache_pkg::LINE_W-1:0] mem_data_i;

  logic [31:0] lfsr_q;

  // Memory responder
  logic        mem_busy;
  int          mem_delay;
  logic [31:0] mem_line_addr;

  // DUT outputs as seen at the falling edge, before anything is driven
  logic        seen_ack;
  logic        seen_mem_req;
  logic [31:0] seen_mem_addr;

  int   done_reqs;
  int   cycles;
  logic timed_out;
  int   chk_errors;
  int   chk_hits;
  int   chk_misses;
  int   total_errors;

  icache_top UUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .kill_i     (kill_i),
    .addr_i     (addr_i),
    .ack_o      (ack_o),
    .instr_o    (instr_o),
    .flush_i    (flush_i),
    .mem_req_o  (mem_req_o),
    .mem_addr_o (mem_addr_o),
    .mem_ack_i  (mem_ack_i),
    .mem_data_i (mem_data_i)
  );

  icache_checker u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .kill_i        (kill_i),
    .flush_i       (flush_i),
    .addr_i        (addr_i),
    .ack_i         (ack_o),
    .instr_i       (instr_o),
    .mem_req_i     (mem_req_o),
    .mem_addr_i    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .error_count_o (chk_errors),
    .hit_count_o   (chk_hits),
    .miss_count_o  (chk_misses)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] step_lfsr(logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic int random_bits(int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      value  = (value << 1) | lfsr_q[0];
      lfsr_q = step_lfsr(lfsr_q);
    end
    return value;
  endfunction

  // Four tags over eight sets, so sets fill up and evict
  function automatic logic [31:0] random_address();
    logic [1:0] tag_sel;
    logic [2:0] idx;
    logic [1:0] ofs;
    tag_sel = random_bits(2);
    idx     = random_bits(3);
    ofs     = random_bits(2);
    return {16'h0001, 6'b0, tag_sel, 1'b0, idx, ofs, 2'b00};
  endfunction

  // Word 0 sits in the low bits of the line
  function automatic logic [icache_pkg::LINE_W-1:0] line_content(logic [31:0] line_addr);
    logic [icache_pkg::LINE_W-1:0] line;
    for (int w = 0; w < icache_pkg::LINE_WORDS; w++) begin
      line[w*32 +: 32] = (line_addr + 32'(4 * w)) ^ CONTENT_KEY;
    end
    return line;
  endfunction

  task automatic respond_memory();
    if (mem_ack_i) begin
      // Ack lasts one cycle
      mem_ack_i = 1'b0;
      mem_busy  = 1'b0;
    end else if (!seen_mem_req) begin
      // Request withdrawn, abandon the read
      mem_busy = 1'b0;
    end else begin
      if (!mem_busy) begin
        mem_busy      = 1'b1;
        mem_line_addr = seen_mem_addr;
        mem_delay     = 1 + random_bits(2);
      end
      mem_delay--;
      if (mem_delay == 0) begin
        mem_ack_i  = 1'b1;
        mem_data_i = line_content(mem_line_addr);
      end
    end
  endtask

  // Next request, or now and then a flush cycle with req_i low
  task automatic start_request();
    if (done_reqs >= NUM_REQS) begin
      req_i = 1'b0;
    end else if (random_bits(4) == 0) begin
      req_i   = 1'b0;
      flush_i = 1'b1;
    end else begin
      req_i  = 1'b1;
      addr_i = random_address();
    end
  endtask

  task automatic drive_fetch();
    if (kill_i) begin
      // Killed request is finished and gets no answer
      kill_i = 1'b0;
      req_i  = 1'b0;
      done_reqs++;
    end else if (flush_i) begin
      flush_i = 1'b0;
      start_request();
    end else if (req_i) begin
      if (seen_ack) begin
        done_reqs++;
        start_request();
      end else if (seen_mem_req && (random_bits(3) == 0)) begin
        // Redirect while the line is being fetched
        kill_i = 1'b1;
      end
    end else begin
      start_request();
    end
  endtask

  initial begin : run
    lfsr_q     = SEED;
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    kill_i     = 1'b0;
    flush_i    = 1'b0;
    addr_i     = '0;
    mem_ack_i  = 1'b0;
    mem_data_i = '0;
    mem_busy   = 1'b0;
    mem_delay  = 0;
    done_reqs  = 0;
    cycles     = 0;
    timed_out  = 1'b0;

    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    while ((done_reqs < NUM_REQS) && !timed_out) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > MAX_CYCLES) begin
        timed_out = 1'b1;
        $display("Timeout: only %0d of %0d requests finished within %0d cycles",
                 done_reqs, NUM_REQS, MAX_CYCLES);
      end else begin
        seen_ack      = ack_o;
        seen_mem_req  = mem_req_o;
        seen_mem_addr = mem_addr_o;
        respond_memory();
        drive_fetch();
      end
    end

    // Last acknowledge still has to reach the checker
    repeat (2) @(negedge clk_i);

    total_errors = chk_errors + UUT.u_sva.error_count + int'(timed_out);
    $display("Errors: checker %0d, sva %0d, timeout %0d (%0d requests, %0d hits, %0d misses)",
             chk_errors, UUT.u_sva.error_count, int'(timed_out), done_reqs, chk_hits,
             chk_misses);
    if (total_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
